// File: design/smc_pkg.sv
// Shared AHB codes, EMI states and APB register offsets for the memory controller
`default_nettype none

package smc_pkg;

  // --------------------
  // AHB-Lite codes

  // Transfer type
  typedef enum logic [1:0] {
    HT_IDLE   = 2'b00,  // No transfer
    HT_BUSY   = 2'b01,  // Master stall inside a burst
    HT_NONSEQ = 2'b10,  // First or single beat
    HT_SEQ    = 2'b11   // Later beat, handled as single
  } htrans_e;

  // Transfer size, codes above word are rejected
  typedef enum logic [2:0] {
    HS_BYTE = 3'b000,
    HS_HALF = 3'b001,
    HS_WORD = 3'b010
  } hsize_e;

  // Slave response
  typedef enum logic [1:0] {
    HR_OKAY  = 2'b00,
    HR_ERROR = 2'b01   // Two-cycle error
  } hresp_e;

  // --------------------
  // EMI sequencer

  typedef enum logic [2:0] {
    ST_IDLE   = 3'd0,  // Bus parked, strobes high
    ST_SETUP  = 3'd1,  // Chip select, address settle
    ST_STROBE = 3'd2,  // Read or write strobe low
    ST_HOLD   = 3'd3,  // Write data hold
    ST_ACK    = 3'd4   // Waiting for req to drop
  } emi_state_e;

  // --------------------
  // APB register map

  localparam logic [4:0] REG_CTRL   = 5'h00;  // Bit 0 enable
  localparam logic [4:0] REG_TIMING = 5'h04;  // Read and write wait counts

endpackage

`default_nettype wire

// File: design/smc_ahb_slave.sv
// AHB-Lite front end: transfer checks, byte lanes, response and request to the EMI side
`timescale 1ns/1ps
`default_nettype none

module smc_ahb_slave
  import smc_pkg::*;
(
  input  logic        hclk,
  input  logic        rst,
  // AHB slave side
  input  logic [31:0] haddr,
  input  htrans_e     htrans,
  input  logic        hsel,
  input  logic        hwrite,
  input  hsize_e      hsize,
  input  logic [31:0] hwdata,
  input  logic        hready,       // Bus-wide ready
  input  logic        cfg_enable,   // From APB block
  output logic [31:0] smc_hrdata,
  output logic        smc_hready,
  output hresp_e      smc_hresp,
  output logic        smc_valid,    // One pulse per accepted transfer
  // Four-phase request to sequencer
  output logic        acc_req,
  output logic        acc_write,
  output logic [31:0] acc_addr,
  output logic [31:0] acc_wdata,
  output logic [3:0]  acc_be,       // Active high lanes
  input  logic        acc_ack,
  input  logic [31:0] acc_rdata
);

  typedef enum logic [1:0] {
    SL_IDLE,  // Free, or last cycle of previous transfer
    SL_DATA,  // First data-phase cycle, hwdata on bus
    SL_REQ,   // Request outstanding
    SL_ERR    // First error cycle
  } sl_state_e;

  sl_state_e  state;
  logic       accept;    // Address phase taken this edge
  logic       align_ok;  // Size and alignment fine
  logic [3:0] be_dec;    // Lanes from size and low address

  assign accept = (state == SL_IDLE) && hsel && hready &&
                  (htrans == HT_NONSEQ || htrans == HT_SEQ);

  // Lane decode, little endian
  always_comb begin
    case (hsize)
      HS_BYTE: begin
        be_dec   = 4'b0001 << haddr[1:0];
        align_ok = 1'b1;
      end
      HS_HALF: begin
        be_dec   = haddr[1] ? 4'b1100 : 4'b0011;
        align_ok = !haddr[0];
      end
      HS_WORD: begin
        be_dec   = 4'b1111;
        align_ok = (haddr[1:0] == 2'b00);
      end
      default: begin  // Oversized
        be_dec   = 4'b0000;
        align_ok = 1'b0;
      end
    endcase
  end

  // --------------------
  // Control FSM
  always_ff @(posedge hclk) begin
    if (rst) begin
      state      <= SL_IDLE;
      acc_req    <= 1'b0;
      smc_hready <= 1'b1;
      smc_hresp  <= HR_OKAY;
      smc_valid  <= 1'b0;
    end else begin
      smc_valid <= accept;
      case (state)
        SL_IDLE: begin
          smc_hready <= 1'b1;
          smc_hresp  <= HR_OKAY;
          if (accept) begin
            smc_hready <= 1'b0;  // Stall data phase
            if (align_ok && cfg_enable) begin
              state <= SL_DATA;
            end else begin
              smc_hresp <= HR_ERROR;  // EMI untouched
              state     <= SL_ERR;
            end
          end
        end
        SL_DATA: begin
          acc_req <= !acc_ack;  // Wait if old ack still up
          state   <= SL_REQ;
        end
        SL_REQ: begin
          if (!acc_req && !acc_ack) begin
            acc_req <= 1'b1;
          end else if (acc_req && acc_ack) begin
            acc_req    <= 1'b0;
            smc_hready <= 1'b1;  // Data phase ends next edge
            state      <= SL_IDLE;
          end
        end
        default: begin  // Second error cycle
          smc_hready <= 1'b1;
          state      <= SL_IDLE;
        end
      endcase
    end
  end

  // Payload, held while acc_req is high
  always_ff @(posedge hclk) begin
    if (accept) begin
      acc_addr  <= haddr;
      acc_write <= hwrite;
      acc_be    <= be_dec;
    end
    if (state == SL_DATA) acc_wdata <= hwdata;
    if (state == SL_REQ && acc_req && acc_ack) smc_hrdata <= acc_rdata;
  end

  // --------------------
  // Checks
  a_req_after_ack: assert property (@(posedge hclk) disable iff (rst)
    $rose(acc_req) |-> !$past(acc_ack));

  // Error opens with ready low, then closes with ready high
  a_err_two_cycle: assert property (@(posedge hclk) disable iff (rst)
    (smc_hresp == HR_ERROR && $past(smc_hresp) != HR_ERROR) |->
      !smc_hready ##1 (smc_hresp == HR_ERROR && smc_hready));

endmodule

`default_nettype wire

// File: design/smc_cfg_regs.sv
// APB configuration registers: controller enable and read/write wait-state counts
`timescale 1ns/1ps
`default_nettype none

module smc_cfg_regs
  import smc_pkg::*;
#(
  parameter int WS_W = 4  // Bits per wait count
) (
  input  logic            hclk,       // APB shares the AHB clock
  input  logic            rst,
  // APB slave, no wait states
  input  logic            psel,
  input  logic            penable,
  input  logic            pwrite,
  input  logic [4:0]      paddr,
  input  logic [31:0]     pwdata,
  output logic [31:0]     prdata,
  // Settings out
  output logic            cfg_enable,
  output logic [WS_W-1:0] cfg_rd_ws,
  output logic [WS_W-1:0] cfg_wr_ws
);

  logic apb_wr;  // Write in access cycle
  logic apb_rd;  // Read, setup or access

  assign apb_wr = psel && penable && pwrite;
  assign apb_rd = psel && !pwrite;

  // --------------------
  // Register writes
  always_ff @(posedge hclk) begin
    if (rst) begin
      cfg_enable <= 1'b1;
      cfg_rd_ws  <= WS_W'(2);
      cfg_wr_ws  <= WS_W'(1);
    end else if (apb_wr) begin
      case (paddr)
        REG_CTRL: begin
          cfg_enable <= pwdata[0];
        end
        REG_TIMING: begin
          cfg_rd_ws <= pwdata[WS_W-1:0];
          cfg_wr_ws <= pwdata[2*WS_W-1:WS_W];  // Next field up
        end
        default: ;  // Unmapped, dropped
      endcase
    end
  end

  // --------------------
  // Read-back mux
  always_comb begin
    prdata = '0;
    if (apb_rd) begin
      case (paddr)
        REG_CTRL:   prdata[0] = cfg_enable;
        REG_TIMING: prdata[2*WS_W-1:0] = {cfg_wr_ws, cfg_rd_ws};
        default:    prdata = '0;  // Unmapped reads zero
      endcase
    end
  end

  // Master protocol
  a_penable_psel: assert property (@(posedge hclk) disable iff (rst)
    penable |-> psel);

endmodule

`default_nettype wire

// File: design/smc_emi_seq.sv
// EMI sequencer FSM: chip select, strobes, byte enables, wait counting and read capture
`timescale 1ns/1ps
`default_nettype none

module smc_emi_seq
  import smc_pkg::*;
#(
  parameter int WS_W = 4
) (
  input  logic            hclk,
  input  logic            rst,
  // Four-phase request from AHB side
  input  logic            acc_req,
  input  logic            acc_write,
  input  logic [31:0]     acc_addr,
  input  logic [31:0]     acc_wdata,
  input  logic [3:0]      acc_be,
  output logic            acc_ack,
  output logic [31:0]     acc_rdata,
  // Wait counts
  input  logic [WS_W-1:0] cfg_rd_ws,
  input  logic [WS_W-1:0] cfg_wr_ws,
  // External memory pins
  input  logic [31:0]     data_smc,
  output logic [31:0]     smc_addr,
  output logic [31:0]     smc_data,
  output logic [3:0]      smc_n_be,
  output logic            smc_n_cs,
  output logic [3:0]      smc_n_we,
  output logic            smc_n_wr,
  output logic            smc_n_rd,
  output logic            smc_n_ext_oe,
  output logic            smc_busy
);

  emi_state_e      state;
  emi_state_e      state_nxt;
  logic [WS_W-1:0] ws_cnt;       // Strobe cycles left minus one
  logic            last_strobe;  // Final strobe cycle
  logic            cyc_nxt;      // Next cycle inside cs window
  logic            strobe_nxt;   // Next cycle is a strobe

  assign last_strobe = (state == ST_STROBE) && (ws_cnt == '0);

  // --------------------
  // Next state
  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE:   if (acc_req) state_nxt = ST_SETUP;
      ST_SETUP:  state_nxt = ST_STROBE;
      ST_STROBE: if (last_strobe) state_nxt = acc_write ? ST_HOLD : ST_ACK;
      ST_HOLD:   state_nxt = ST_ACK;
      ST_ACK:    if (!acc_req) state_nxt = ST_IDLE;  // Four-phase close
      default:   state_nxt = ST_IDLE;
    endcase
  end

  assign cyc_nxt    = (state_nxt == ST_SETUP) || (state_nxt == ST_STROBE) ||
                      (state_nxt == ST_HOLD);
  assign strobe_nxt = (state_nxt == ST_STROBE);

  // --------------------
  // State, counter and pins
  // Pins are decoded from the next state so they change on clean edges
  always_ff @(posedge hclk) begin
    if (rst) begin
      state        <= ST_IDLE;
      ws_cnt       <= '0;
      acc_ack      <= 1'b0;
      smc_busy     <= 1'b0;
      smc_n_cs     <= 1'b1;
      smc_n_be     <= 4'hf;
      smc_n_we     <= 4'hf;
      smc_n_wr     <= 1'b1;
      smc_n_rd     <= 1'b1;
      smc_n_ext_oe <= 1'b1;
    end else begin
      state <= state_nxt;

      // Load at setup, count down through strobe
      if (state == ST_SETUP) begin
        ws_cnt <= acc_write ? cfg_wr_ws : cfg_rd_ws;
      end else if (state == ST_STROBE && !last_strobe) begin
        ws_cnt <= ws_cnt - 1'b1;
      end

      acc_ack      <= (state_nxt == ST_ACK);
      smc_busy     <= (state_nxt != ST_IDLE);
      smc_n_cs     <= !cyc_nxt;
      smc_n_be     <= cyc_nxt ? ~acc_be : 4'hf;                  // Whole access
      smc_n_we     <= (strobe_nxt && acc_write) ? ~acc_be : 4'hf;
      smc_n_rd     <= !(strobe_nxt && !acc_write);
      smc_n_wr     <= !(cyc_nxt && acc_write);                   // Setup to hold
      smc_n_ext_oe <= !(cyc_nxt && acc_write);                   // Drive data bus
    end
  end

  // --------------------
  // Address, write data, read data
  always_ff @(posedge hclk) begin
    if (state == ST_IDLE && acc_req) begin
      smc_addr <= acc_addr;
      smc_data <= acc_wdata;
    end
    if (last_strobe && !acc_write) acc_rdata <= data_smc;  // Sample before rd rises
  end

  // Read and write windows never overlap on the pins
  a_rd_wr_excl: assert property (@(posedge hclk) disable iff (rst)
    !(!smc_n_rd && !smc_n_wr));

endmodule

`default_nettype wire

// File: design/smc_veneer.sv
// Controller top: AHB front end, APB config registers and EMI sequencer
`timescale 1ns/1ps
`default_nettype none

module smc_veneer
  import smc_pkg::*;
#(
  parameter int WS_W = 4  // Wait count width
) (
  input  logic        hclk,          // System clock, AHB and APB
  input  logic        rst,           // Sync, active high
  // AHB-Lite
  input  logic [31:0] haddr,
  input  htrans_e     htrans,
  input  logic        hsel,
  input  logic        hwrite,
  input  hsize_e      hsize,
  input  logic [31:0] hwdata,
  input  logic        hready,
  output logic [31:0] smc_hrdata,
  output logic        smc_hready,
  output hresp_e      smc_hresp,
  output logic        smc_valid,
  // APB
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [4:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  // External memory
  output logic [31:0] smc_addr,
  output logic [31:0] smc_data,      // Write data out
  input  logic [31:0] data_smc,      // Read data in
  output logic [3:0]  smc_n_be,
  output logic        smc_n_cs,
  output logic [3:0]  smc_n_we,
  output logic        smc_n_wr,
  output logic        smc_n_rd,
  output logic        smc_n_ext_oe,
  output logic        smc_busy
);

  // Front end to sequencer
  logic            acc_req;
  logic            acc_write;
  logic [31:0]     acc_addr;
  logic [31:0]     acc_wdata;
  logic [3:0]      acc_be;
  logic            acc_ack;
  logic [31:0]     acc_rdata;
  // Configuration
  logic            cfg_enable;
  logic [WS_W-1:0] cfg_rd_ws;
  logic [WS_W-1:0] cfg_wr_ws;

  smc_ahb_slave i_ahb_slave (
    .hclk(hclk), .rst(rst),
    .haddr(haddr), .htrans(htrans), .hsel(hsel), .hwrite(hwrite),
    .hsize(hsize), .hwdata(hwdata), .hready(hready), .cfg_enable(cfg_enable),
    .smc_hrdata(smc_hrdata), .smc_hready(smc_hready),
    .smc_hresp(smc_hresp), .smc_valid(smc_valid),
    .acc_req(acc_req), .acc_write(acc_write), .acc_addr(acc_addr),
    .acc_wdata(acc_wdata), .acc_be(acc_be),
    .acc_ack(acc_ack), .acc_rdata(acc_rdata)
  );

  smc_cfg_regs #(.WS_W(WS_W)) i_cfg_regs (
    .hclk(hclk), .rst(rst),
    .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
    .cfg_enable(cfg_enable), .cfg_rd_ws(cfg_rd_ws), .cfg_wr_ws(cfg_wr_ws)
  );

  smc_emi_seq #(.WS_W(WS_W)) i_emi_seq (
    .hclk(hclk), .rst(rst),
    .acc_req(acc_req), .acc_write(acc_write), .acc_addr(acc_addr),
    .acc_wdata(acc_wdata), .acc_be(acc_be),
    .acc_ack(acc_ack), .acc_rdata(acc_rdata),
    .cfg_rd_ws(cfg_rd_ws), .cfg_wr_ws(cfg_wr_ws),
    .data_smc(data_smc), .smc_addr(smc_addr), .smc_data(smc_data),
    .smc_n_be(smc_n_be), .smc_n_cs(smc_n_cs), .smc_n_we(smc_n_we),
    .smc_n_wr(smc_n_wr), .smc_n_rd(smc_n_rd),
    .smc_n_ext_oe(smc_n_ext_oe), .smc_busy(smc_busy)
  );

endmodule

`default_nettype wire

// File: tests/smc_sram_model.sv
// Behavioural asynchronous SRAM on the EMI pins, with strobe width and chip select counters
`timescale 1ns/1ps
`default_nettype none

module smc_sram_model (
  input  logic        hclk,        // Only used to measure widths
  input  logic [31:0] smc_addr,
  input  logic [31:0] smc_data,
  input  logic [3:0]  smc_n_be,
  input  logic        smc_n_cs,
  input  logic [3:0]  smc_n_we,
  input  logic        smc_n_rd,
  output logic [31:0] data_smc,
  output int          cs_width,    // Last chip select pulse, cycles
  output int          rd_width,    // Last read strobe, cycles
  output int          we_width,    // Last write strobe, cycles
  output int          cs_cycles    // All cycles with chip select low
);

  logic [31:0] mem [0:255];  // 1 KB, word indexed
  logic [3:0]  we_q;         // Previous write strobes

  // Read path is purely combinational
  assign data_smc = (smc_n_cs === 1'b0 && smc_n_rd === 1'b0) ? mem[smc_addr[9:2]] : '0;

  // Byte lanes latch on the rising write strobe
  initial we_q = 4'hf;
  always @(smc_n_we) begin : lane_store
    int i;
    for (i = 0; i < 4; i++) begin
      if (we_q[i] === 1'b0 && smc_n_we[i] === 1'b1 &&
          smc_n_cs === 1'b0 && smc_n_be[i] === 1'b0) begin
        mem[smc_addr[9:2]][8*i +: 8] = smc_data[8*i +: 8];
      end
    end
    we_q = smc_n_we;
  end

  // --------------------
  // Pulse widths, sampled mid-cycle
  initial begin : width_meter
    int cs_run;
    int rd_run;
    int we_run;
    cs_run    = 0;
    rd_run    = 0;
    we_run    = 0;
    cs_width  = 0;
    rd_width  = 0;
    we_width  = 0;
    cs_cycles = 0;
    forever begin
      @(negedge hclk);
      if (smc_n_cs === 1'b0) begin
        cs_run++;
        cs_cycles++;
        if (smc_n_rd === 1'b0) rd_run++;
        if (smc_n_we !== 4'hf) we_run++;  // Any lane low
      end else if (cs_run != 0) begin     // Pulse just ended
        cs_width = cs_run;
        if (rd_run != 0) rd_width = rd_run;
        if (we_run != 0) we_width = we_run;
        cs_run = 0;
        rd_run = 0;
        we_run = 0;
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_smc.sv
// Testbench for smc_veneer: clock, reset, AHB and APB drivers, compare tasks, directed tests
`timescale 1ns/1ps
`default_nettype none

module tb_smc
  import smc_pkg::*;
;

  localparam int WS_W       = 4;
  localparam int MAX_CYCLES = 4000;  // ~35 transfers of up to 20 cycles, wide margin

  logic        hclk;
  logic        rst;
  logic [31:0] haddr;
  htrans_e     htrans;
  logic        hsel;
  logic        hwrite;
  hsize_e      hsize;
  logic [31:0] hwdata;
  logic        hready;
  logic [31:0] smc_hrdata;
  logic        smc_hready;
  hresp_e      smc_hresp;
  logic        smc_valid;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [4:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic [31:0] smc_addr;
  logic [31:0] smc_data;
  logic [31:0] data_smc;
  logic [3:0]  smc_n_be;
  logic        smc_n_cs;
  logic [3:0]  smc_n_we;
  logic        smc_n_wr;
  logic        smc_n_rd;
  logic        smc_n_ext_oe;
  logic        smc_busy;
  int          cs_width;
  int          rd_width;
  int          we_width;
  int          cs_cycles;

  int          errors    = 0;
  int          valid_cnt = 0;
  int          cycles    = 0;
  logic [31:0] rng       = 32'h8bd5_993a;

  smc_veneer #(.WS_W(WS_W)) i_dut (
    .hclk(hclk), .rst(rst),
    .haddr(haddr), .htrans(htrans), .hsel(hsel), .hwrite(hwrite), .hsize(hsize),
    .hwdata(hwdata), .hready(hready), .smc_hrdata(smc_hrdata), .smc_hready(smc_hready),
    .smc_hresp(smc_hresp), .smc_valid(smc_valid),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata),
    .smc_addr(smc_addr), .smc_data(smc_data), .data_smc(data_smc), .smc_n_be(smc_n_be),
    .smc_n_cs(smc_n_cs), .smc_n_we(smc_n_we), .smc_n_wr(smc_n_wr), .smc_n_rd(smc_n_rd),
    .smc_n_ext_oe(smc_n_ext_oe), .smc_busy(smc_busy)
  );

  smc_sram_model i_sram (
    .hclk(hclk), .smc_addr(smc_addr), .smc_data(smc_data), .smc_n_be(smc_n_be),
    .smc_n_cs(smc_n_cs), .smc_n_we(smc_n_we), .smc_n_rd(smc_n_rd), .data_smc(data_smc),
    .cs_width(cs_width), .rd_width(rd_width), .we_width(we_width), .cs_cycles(cs_cycles)
  );

  initial begin
    hclk = 1'b0;
    forever #2 hclk = ~hclk;  // 4 ns period
  end

  // Watchdog
  initial begin
    while (cycles < MAX_CYCLES) begin
      @(posedge hclk);
      cycles++;
    end
    $display("Timeout: run still going after %0d cycles, a transfer never completed", cycles);
    $display("Errors found");
    $finish;
  end

  always @(negedge hclk) if (smc_valid === 1'b1) valid_cnt++;  // Accepted address phases

  // --------------------
  // Stimulus helpers
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [31:0] rand_addr();
    logic [31:0] r;
    r = next_rand();
    return {22'h0, r[9:2], 2'b00};  // Word aligned, inside the model
  endfunction

  // Little-endian lane merge per AHB size and low address bits
  function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] wd,
                                              input logic [1:0] low, input hsize_e sz);
    logic [31:0] res;
    logic        hit;
    int          i;
    res = old;
    for (i = 0; i < 4; i++) begin
      case (sz)
        HS_BYTE: hit = (i == low);
        HS_HALF: hit = (i[1] == low[1]);
        default: hit = 1'b1;
      endcase
      if (hit) res[8*i +: 8] = wd[8*i +: 8];
    end
    return res;
  endfunction

  // --------------------
  // Compare tasks
  task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input hresp_e exp, input hresp_e act);
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      errors++;
      $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  // --------------------
  // Bus drivers, entered and left on a falling edge
  task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge hclk);
    penable = 1'b1;  // Access cycle
    @(negedge hclk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [4:0] addr, output logic [31:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge hclk);
    penable = 1'b1;
    @(posedge hclk);
    data    = prdata;  // Valid through the access cycle
    @(negedge hclk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic ahb_transfer(input logic wr, input logic [31:0] addr, input hsize_e sz,
                              input logic [31:0] wd, output logic [31:0] rd,
                              output hresp_e first_resp, output logic first_ready,
                              output hresp_e last_resp, output logic busy_seen);
    haddr  = addr;
    htrans = HT_NONSEQ;
    hsel   = 1'b1;
    hwrite = wr;
    hsize  = sz;
    hready = 1'b1;
    @(negedge hclk);  // First data-phase cycle
    htrans      = HT_IDLE;
    hsel        = 1'b0;
    hwdata      = wd;
    first_resp  = smc_hresp;
    first_ready = smc_hready;
    busy_seen   = 1'b0;
    while (smc_hready !== 1'b1) begin
      @(negedge hclk);
      if (smc_busy === 1'b1) busy_seen = 1'b1;
    end
    rd        = smc_hrdata;
    last_resp = smc_hresp;
    @(negedge hclk);  // Sequencer back to idle
  endtask

  task automatic legal_access(input logic wr, input logic [31:0] addr, input hsize_e sz,
                              input logic [31:0] wd, output logic [31:0] rd);
    hresp_e r1;
    hresp_e r2;
    logic   rdy1;
    logic   busy;
    ahb_transfer(wr, addr, sz, wd, rd, r1, rdy1, r2, busy);
    check_resp("smc_hresp first data cycle", HR_OKAY, r1);
    check_data("smc_hready first data cycle", 32'h0, {31'h0, rdy1});  // Stalled
    check_resp("smc_hresp last data cycle", HR_OKAY, r2);
    if (!busy) begin
      errors++;
      $display("smc_busy never rose during the access to %h at %0t", addr, $time);
    end
    check_data("smc_busy after access", 32'h0, {31'h0, smc_busy});
  endtask

  task automatic rejected_access(input logic wr, input logic [31:0] addr, input hsize_e sz);
    logic [31:0] rd;
    hresp_e      r1;
    hresp_e      r2;
    logic        rdy1;
    logic        busy;
    ahb_transfer(wr, addr, sz, 32'hdead_beef, rd, r1, rdy1, r2, busy);
    check_resp("smc_hresp first error cycle", HR_ERROR, r1);
    check_data("smc_hready first error cycle", 32'h0, {31'h0, rdy1});
    check_resp("smc_hresp second error cycle", HR_ERROR, r2);
  endtask

  // --------------------
  // Directed tests
  task automatic reset_values();
    check_data("smc_hready", 32'h1, {31'h0, smc_hready});
    check_resp("smc_hresp", HR_OKAY, smc_hresp);
    check_data("smc_valid", 32'h0, {31'h0, smc_valid});
    check_data("smc_busy", 32'h0, {31'h0, smc_busy});
    check_data("smc_n_cs", 32'h1, {31'h0, smc_n_cs});
    check_data("smc_n_rd", 32'h1, {31'h0, smc_n_rd});
    check_data("smc_n_wr", 32'h1, {31'h0, smc_n_wr});
    check_data("smc_n_we", 32'hf, {28'h0, smc_n_we});
    check_data("smc_n_ext_oe", 32'h1, {31'h0, smc_n_ext_oe});
  endtask

  task automatic word_readback();
    logic [31:0] addr;
    logic [31:0] d;
    logic [31:0] rd;
    int          v0;
    int          k;
    v0 = valid_cnt;
    for (k = 0; k < 4; k++) begin
      addr = rand_addr();
      d    = next_rand();
      legal_access(1'b1, addr, HS_WORD, d, rd);
      legal_access(1'b0, addr, HS_WORD, 32'h0, rd);
      check_data("smc_hrdata", d, rd);
    end
    check_count("smc_valid pulses", 8, valid_cnt - v0);  // One per transfer
  endtask

  task automatic partial_writes();
    logic [31:0] addr;
    logic [31:0] r;
    logic [31:0] d;
    logic [31:0] rd;
    logic [31:0] expect_word;
    logic [1:0]  low;
    hsize_e      sz;
    int          n;
    int          k;
    for (n = 0; n < 3; n++) begin
      addr        = rand_addr();
      expect_word = next_rand();
      legal_access(1'b1, addr, HS_WORD, expect_word, rd);  // Known base
      for (k = 0; k < 3; k++) begin
        r   = next_rand();
        sz  = (k == 2) ? HS_HALF : HS_BYTE;
        low = (sz == HS_HALF) ? {r[9], 1'b0} : r[9:8];
        d   = (sz == HS_HALF) ? {2{r[15:0]}} : {4{r[7:0]}};  // Data on every lane
        legal_access(1'b1, addr | low, sz, d, rd);
        expect_word = merge_lanes(expect_word, d, low, sz);
      end
      legal_access(1'b0, addr, HS_WORD, 32'h0, rd);
      check_data("smc_hrdata merged", expect_word, rd);
    end
  endtask

  task automatic wait_state_widths();
    logic [31:0]     r;
    logic [31:0]     addr;
    logic [31:0]     d;
    logic [31:0]     rd;
    logic [31:0]     cfg;
    logic [WS_W-1:0] rd_ws;
    logic [WS_W-1:0] wr_ws;
    int              k;
    for (k = 0; k < 2; k++) begin
      r     = next_rand();
      rd_ws = (k == 0) ? WS_W'(r[2:0]) : '0;  // Random, then shortest
      wr_ws = (k == 0) ? WS_W'(r[6:4]) : '0;
      apb_write(REG_TIMING, 32'({wr_ws, rd_ws}));
      apb_read(REG_TIMING, cfg);
      check_data("prdata REG_TIMING", 32'({wr_ws, rd_ws}), cfg);
      addr = rand_addr();
      d    = next_rand();
      legal_access(1'b1, addr, HS_WORD, d, rd);
      check_count("smc_n_we width", wr_ws + 1, we_width);
      check_count("smc_n_cs width on write", wr_ws + 3, cs_width);  // Setup, strobe, hold
      legal_access(1'b0, addr, HS_WORD, 32'h0, rd);
      check_data("smc_hrdata", d, rd);
      check_count("smc_n_rd width", rd_ws + 1, rd_width);
      check_count("smc_n_cs width on read", rd_ws + 2, cs_width);
    end
    apb_write(5'h08, 32'hffff_ffff);  // Unmapped
    apb_read(5'h08, cfg);
    check_data("prdata unmapped", 32'h0, cfg);
    apb_read(REG_TIMING, cfg);
    check_data("prdata REG_TIMING", 32'({wr_ws, rd_ws}), cfg);
    apb_read(REG_CTRL, cfg);
    check_data("prdata REG_CTRL", 32'h1, cfg);
  endtask

  task automatic error_responses();
    logic [31:0] addr;
    logic [31:0] d;
    logic [31:0] rd;
    logic [31:0] cfg;
    int          cs0;
    addr = rand_addr();
    d    = next_rand();
    legal_access(1'b1, addr, HS_WORD, d, rd);
    cs0 = cs_cycles;
    rejected_access(1'b0, addr, hsize_e'(3'b011));  // Doubleword
    rejected_access(1'b0, addr | 32'h2, HS_WORD);   // Misaligned word
    rejected_access(1'b1, addr | 32'h1, HS_HALF);   // Misaligned half
    apb_write(REG_CTRL, 32'h0);
    apb_read(REG_CTRL, cfg);
    check_data("prdata REG_CTRL", 32'h0, cfg);
    rejected_access(1'b1, addr, HS_WORD);
    rejected_access(1'b0, addr, HS_BYTE);
    check_count("chip select cycles during errors", cs0, cs_cycles);
    apb_write(REG_CTRL, 32'h1);
    legal_access(1'b0, addr, HS_WORD, 32'h0, rd);
    check_data("smc_hrdata after rejected write", d, rd);  // Memory untouched
  endtask

  // --------------------
  // Main sequence
  initial begin
    rst     = 1'b1;
    haddr   = '0;
    htrans  = HT_IDLE;
    hsel    = 1'b0;
    hwrite  = 1'b0;
    hsize   = HS_WORD;
    hwdata  = '0;
    hready  = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (4) @(posedge hclk);
    @(negedge hclk);
    rst = 1'b0;
    reset_values();
    word_readback();
    partial_writes();
    wait_state_widths();
    error_responses();
    @(negedge hclk);
    $display("Run complete after %0d cycles, %0d error(s)", cycles, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
design/smc_pkg.sv
design/smc_ahb_slave.sv
design/smc_cfg_regs.sv
design/smc_emi_seq.sv
design/smc_veneer.sv
tests/smc_sram_model.sv
tests/tb_smc.sv

// File: Bender.yml
package:
  name: smc_lite

sources:
  - design/smc_pkg.sv
  - design/smc_ahb_slave.sv
  - design/smc_cfg_regs.sv
  - design/smc_emi_seq.sv
  - design/smc_veneer.sv
  - target: test
    files:
      - tests/smc_sram_model.sv
      - tests/tb_smc.sv
